/* design/housekeepingPkg.sv */
// shared constants and bundle types for the board housekeeping blocks, imported by each module
package housekeepingPkg;

    // time base
    localparam int unsigned SECOND_TICKS = 8388608;  // gClk cycles per second
    localparam int unsigned BLINK_BIT = 4;           // counter bit driving the led blink

    // cartridge detect filter
    localparam int unsigned CART_HISTORY = 18;
    localparam int unsigned CART_STABLE_LO = 3;      // stable window, all ones when settled
    localparam int unsigned CART_STABLE_HI = 6;

    // companion mcu boot delay
    localparam int unsigned MCU_STEP_BITS = 12;      // one step is 4096 cycles
    localparam int unsigned MCU_DELAY_DEPTH = 8;

    // lcd enable waits this many vsync edges
    localparam int unsigned LCD_STAGE_DEPTH = 3;

    typedef struct packed {
        logic second;  // one cycle strobe
        logic blink;
    } tickBus_t;

    typedef struct packed {
        logic white;
        logic green;
        logic yellow;
        logic red;
    } ledRequest_t;

    // active low, 1 switches the color off
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } ledRgb_t;

    typedef struct packed {
        logic enable;
        logic bootSel;
    } mcuCtrl_t;

endpackage

/* design/tickGen.sv */
// one-second time base, gives a single-cycle second strobe and a blink bit to the consumers
`timescale 1ns/1ps

module tickGen #(
    parameter int unsigned ticksPerSecond = housekeepingPkg::SECOND_TICKS
) (
    input  logic                      gClk,
    input  logic                      lock_o,
    output housekeepingPkg::tickBus_t tick_o
);

    import housekeepingPkg::*;

    logic [$clog2(ticksPerSecond)-1:0] cycleCnt;
    logic                              secondQ;
    logic                              atTop;

    assign atTop = (cycleCnt == $bits(cycleCnt)'(ticksPerSecond - 1));

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            cycleCnt <= '0;
        end else if (atTop) begin
            cycleCnt <= '0;  // wrap once per second
        end else begin
            cycleCnt <= cycleCnt + 1'b1;
        end
    end

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            secondQ <= 1'b0;
        end else begin
            secondQ <= atTop;  // registered strobe
        end
    end

    // blink reuses a low bit of the second counter
    assign tick_o.second = secondQ;
    assign tick_o.blink  = cycleCnt[BLINK_BIT];

endmodule

/* design/stageLine.sv */
// serial shift chain that moves one stage per advance strobe, used for the lcd and mcu delays
`timescale 1ns/1ps

module stageLine #(
    parameter int unsigned depth = 3
) (
    input  logic gClk,
    input  logic lock_o,
    input  logic advance_i,
    input  logic clear_i,
    input  logic data_i,
    output logic data_o
);

    logic [depth-1:0] stages;  // bit 0 newest

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            stages <= '0;
        end else if (clear_i) begin
            stages <= '0;  // clear wins over advance
        end else if (advance_i) begin
            stages <= (stages << 1) | depth'(data_i);
        end
    end

    assign data_o = stages[depth-1];  // oldest stage

endmodule

/* design/cartGuard.sv */
// cartridge-detect filter, pulses memory reset on a settled level change and gates the menu button
`timescale 1ns/1ps

module cartGuard (
    input  logic gClk,
    input  logic lock_o,
    input  logic cartDetect_i,
    input  logic menuInit_i,
    input  logic menuBtn_i,     // active low
    output logic memReset_o,
    output logic menuGated_o
);

    import housekeepingPkg::*;

    logic [CART_HISTORY-1:0] history;  // msb oldest
    logic                    settledRise;
    logic                    settledFall;
    logic                    cartStable;

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            history <= '0;
        end else begin
            history <= {history[CART_HISTORY-2:0], cartDetect_i};
        end
    end

    // one transition left at the oldest end of the upper window
    assign settledRise =
        (history[CART_HISTORY-1:2] == {1'b0, {(CART_HISTORY - 3){1'b1}}});
    assign settledFall =
        (history[CART_HISTORY-1:2] == {1'b1, {(CART_HISTORY - 3){1'b0}}});

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            memReset_o <= 1'b1;  // memories held during reset
        end else begin
            memReset_o <= settledRise | settledFall;
        end
    end

    assign cartStable = &history[CART_STABLE_HI:CART_STABLE_LO];

    // button reads released until the cart line has been high for a while
    assign menuGated_o = (menuInit_i && cartStable) ? menuBtn_i : 1'b1;

endmodule

/* design/peripheralSequencer.sv */
// lcd enable staging, delayed mcu enable and boot select, and usb reset hold after lock
`timescale 1ns/1ps

module peripheralSequencer (
    input  logic                      gClk,
    input  logic                      lock_o,
    input  housekeepingPkg::tickBus_t tick_i,
    input  logic                      memReset_i,
    input  logic                      lcdVsync_i,
    input  logic                      lcdReady_i,
    input  logic                      mcuEnableReq_i,
    input  logic                      mcuBootReq_i,
    output logic                      lcdEnable_o,
    output housekeepingPkg::mcuCtrl_t mcu_o,
    output logic                      usbReset_o
);

    import housekeepingPkg::*;

    logic                     vsyncQ;
    logic                     vsyncQQ;
    logic                     lcdAdvance;

    logic [MCU_STEP_BITS-1:0] stepCnt;
    logic                     stepTick;
    logic                     enableReqQ;
    logic                     mcuClear;
    logic                     mcuDelayed;

    // lcd path
    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            vsyncQ  <= 1'b0;
            vsyncQQ <= 1'b0;
        end else begin
            vsyncQ  <= lcdVsync_i;
            vsyncQQ <= vsyncQ;
        end
    end

    assign lcdAdvance = vsyncQ & ~vsyncQQ;  // one cycle after the rising edge

    stageLine #(
        .depth(LCD_STAGE_DEPTH)
    ) lcdStages (
        .gClk     (gClk),
        .lock_o   (lock_o),
        .advance_i(lcdAdvance),
        .clear_i  (memReset_i),
        .data_i   (lcdReady_i),
        .data_o   (lcdEnable_o)
    );

    // mcu path, free running step counter
    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            stepCnt    <= '0;
            enableReqQ <= 1'b0;
        end else begin
            stepCnt    <= stepCnt + 1'b1;
            enableReqQ <= mcuEnableReq_i;
        end
    end

    assign stepTick = (stepCnt == '0);
    assign mcuClear = ~enableReqQ;

    stageLine #(
        .depth(MCU_DELAY_DEPTH)
    ) mcuStages (
        .gClk     (gClk),
        .lock_o   (lock_o),
        .advance_i(stepTick),
        .clear_i  (mcuClear),
        .data_i   (enableReqQ),
        .data_o   (mcuDelayed)
    );

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            mcu_o.enable  <= 1'b0;
            mcu_o.bootSel <= 1'b0;
        end else begin
            mcu_o.bootSel <= mcuBootReq_i;
            if (mcuClear) begin
                mcu_o.enable <= 1'b0;  // drop at once, no delay on the way down
            end else if (stepTick) begin
                mcu_o.enable <= mcuDelayed;
            end
        end
    end

    // usb path, held until the first second
    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            usbReset_o <= 1'b1;
        end else if (tick_i.second) begin
            usbReset_o <= 1'b0;
        end
    end

endmodule

/* design/statusLed.sv */
// priority mux from status requests to the registered active-low rgb led
`timescale 1ns/1ps

module statusLed (
    input  logic                         gClk,
    input  logic                         lock_o,
    input  housekeepingPkg::ledRequest_t request_i,
    input  housekeepingPkg::tickBus_t    tick_i,
    output housekeepingPkg::ledRgb_t     led_o
);

    import housekeepingPkg::*;

    ledRgb_t nextLed;

    // white > green > yellow > red > off
    always_comb begin
        if (request_i.white) begin
            nextLed = '{r: 1'b0, g: 1'b0, b: 1'b0};
        end else if (request_i.green) begin
            nextLed = '{r: 1'b1, g: 1'b0, b: 1'b1};
        end else if (request_i.yellow) begin
            nextLed = '{r: 1'b0, g: tick_i.blink, b: 1'b1};  // flickers with blink
        end else if (request_i.red) begin
            nextLed = '{r: 1'b0, g: 1'b1, b: 1'b1};
        end else begin
            nextLed = '{r: 1'b1, g: 1'b1, b: 1'b1};
        end
    end

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            led_o <= '{r: 1'b1, g: 1'b1, b: 1'b1};  // off
        end else begin
            led_o <= nextLed;
        end
    end

endmodule

/* design/boardTop.sv */
// housekeeping top level, connects the time base, cart guard, sequencer and status led
`timescale 1ns/1ps

module boardTop #(
    parameter int unsigned ticksPerSecond = housekeepingPkg::SECOND_TICKS
) (
    input  logic                         gClk,
    input  logic                         lock_o,
    input  logic                         cartDetect_i,
    input  logic                         menuInit_i,
    input  logic                         menuBtn_i,
    input  logic                         lcdVsync_i,
    input  logic                         lcdReady_i,
    input  logic                         mcuEnableReq_i,
    input  logic                         mcuBootReq_i,
    input  housekeepingPkg::ledRequest_t ledRequest_i,
    output logic                         memReset_o,
    output logic                         menuGated_o,
    output logic                         lcdEnable_o,
    output housekeepingPkg::mcuCtrl_t    mcu_o,
    output logic                         usbReset_o,
    output housekeepingPkg::ledRgb_t     led_o
);

    import housekeepingPkg::*;

    tickBus_t tick;

    tickGen #(
        .ticksPerSecond(ticksPerSecond)
    ) tickGenInst (
        .gClk  (gClk),
        .lock_o(lock_o),
        .tick_o(tick)
    );

    cartGuard cartGuardInst (
        .gClk        (gClk),
        .lock_o      (lock_o),
        .cartDetect_i(cartDetect_i),
        .menuInit_i  (menuInit_i),
        .menuBtn_i   (menuBtn_i),
        .memReset_o  (memReset_o),
        .menuGated_o (menuGated_o)
    );

    // memReset also clears the lcd stages
    peripheralSequencer peripheralSequencerInst (
        .gClk          (gClk),
        .lock_o        (lock_o),
        .tick_i        (tick),
        .memReset_i    (memReset_o),
        .lcdVsync_i    (lcdVsync_i),
        .lcdReady_i    (lcdReady_i),
        .mcuEnableReq_i(mcuEnableReq_i),
        .mcuBootReq_i  (mcuBootReq_i),
        .lcdEnable_o   (lcdEnable_o),
        .mcu_o         (mcu_o),
        .usbReset_o    (usbReset_o)
    );

    statusLed statusLedInst (
        .gClk     (gClk),
        .lock_o   (lock_o),
        .request_i(ledRequest_i),
        .tick_i   (tick),
        .led_o    (led_o)
    );

endmodule

/* testbench/boardTop_assert.sv */
// sequencer assertions, bound into every peripheralSequencer instance during simulation
`timescale 1ns/1ps

module boardTop_assert (
    input logic                      gClk,
    input logic                      lock_o,
    input logic                      lcdAdvance_i,
    input logic                      lcdEnable_i,
    input logic                      mcuEnableReq_i,
    input housekeepingPkg::mcuCtrl_t mcu_i,
    input logic                      usbReset_i
);

    int failCount = 0;  // read by the testbench at the end

    lcdNeedsVsync: assert property (@(posedge gClk) disable iff (!lock_o)
        $rose(lcdEnable_i) |-> $past(lcdAdvance_i))
    else begin
        $error("lcdEnable rose without a vsync edge");
        failCount++;
    end

    // enable drops at once when the request goes away
    mcuDropsFast: assert property (@(posedge gClk) disable iff (!lock_o)
        $fell(mcuEnableReq_i) |-> ##[0:2] !mcu_i.enable)
    else begin
        $error("mcu enable still high 2 cycles after the request fell");
        failCount++;
    end

    usbStaysReleased: assert property (@(posedge gClk) disable iff (!lock_o)
        !$rose(usbReset_i))
    else begin
        $error("usbReset asserted again after release");
        failCount++;
    end

endmodule

bind peripheralSequencer boardTop_assert assertInst (
    .gClk          (gClk),
    .lock_o        (lock_o),
    .lcdAdvance_i  (lcdAdvance),
    .lcdEnable_i   (lcdEnable_o),
    .mcuEnableReq_i(mcuEnableReq_i),
    .mcu_i         (mcu_o),
    .usbReset_i    (usbReset_o)
);

/* testbench/boardTop_tb.sv */
// directed testbench for the board housekeeping top level, run as the simulation top
`timescale 1ns/1ps

module boardTop_tb;

    import housekeepingPkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int TICKS = 1000;                   // short second for simulation
    localparam int MCU_STEP = 1 << MCU_STEP_BITS;
    localparam int TEST_CYCLES = 5 + 1100 + 250 + 150 + 200 + (9 * MCU_STEP + 100) + 150;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic        gClk = 1'b0;
    logic        lock_o;
    logic        cartDetect_i;
    logic        menuInit_i;
    logic        menuBtn_i;
    logic        lcdVsync_i;
    logic        lcdReady_i;
    logic        mcuEnableReq_i;
    logic        mcuBootReq_i;
    ledRequest_t ledRequest_i;
    logic        memReset_o;
    logic        menuGated_o;
    logic        lcdEnable_o;
    mcuCtrl_t    mcu_o;
    logic        usbReset_o;
    ledRgb_t     led_o;
    int          seed = 59553;

    boardTop #(
        .ticksPerSecond(TICKS)
    ) DUT (
        .gClk          (gClk),
        .lock_o        (lock_o),
        .cartDetect_i  (cartDetect_i),
        .menuInit_i    (menuInit_i),
        .menuBtn_i     (menuBtn_i),
        .lcdVsync_i    (lcdVsync_i),
        .lcdReady_i    (lcdReady_i),
        .mcuEnableReq_i(mcuEnableReq_i),
        .mcuBootReq_i  (mcuBootReq_i),
        .ledRequest_i  (ledRequest_i),
        .memReset_o    (memReset_o),
        .menuGated_o   (menuGated_o),
        .lcdEnable_o   (lcdEnable_o),
        .mcu_o         (mcu_o),
        .usbReset_o    (usbReset_o),
        .led_o         (led_o)
    );

    always #(CLK_PERIOD / 2) gClk = ~gClk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic compareBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("Error: time %0t, %s, got %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic compareLed(input ledRgb_t got, input ledRgb_t exp, input bit checkGreen,
                              input string what);
        if (got.r !== exp.r || got.b !== exp.b || (checkGreen && got.g !== exp.g)) begin
            abortRun($sformatf("Error: time %0t, %s, got %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic compareMcu(input mcuCtrl_t got, input mcuCtrl_t exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("Error: time %0t, %s, got %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    // active-low color per request priority, green of yellow left open
    function automatic ledRgb_t expectedLed(input ledRequest_t req);
        ledRgb_t led;
        if (req.white) led = '{r: 1'b0, g: 1'b0, b: 1'b0};
        else if (req.green) led = '{r: 1'b1, g: 1'b0, b: 1'b1};
        else if (req.yellow) led = '{r: 1'b0, g: 1'b0, b: 1'b1};
        else if (req.red) led = '{r: 1'b0, g: 1'b1, b: 1'b1};
        else led = '{r: 1'b1, g: 1'b1, b: 1'b1};
        return led;
    endfunction

    task automatic applyReset;
        repeat (4) @(posedge gClk);
        @(negedge gClk);
        compareBit(memReset_o, 1'b1, "memReset_o in reset");
        compareBit(usbReset_o, 1'b1, "usbReset_o in reset");
        compareBit(lcdEnable_o, 1'b0, "lcdEnable_o in reset");
        compareBit(menuGated_o, 1'b1, "menuGated_o in reset");
        compareMcu(mcu_o, '{enable: 1'b0, bootSel: 1'b0}, "mcu_o in reset");
        compareLed(led_o, '{r: 1'b1, g: 1'b1, b: 1'b1}, 1'b1, "led_o in reset");
        @(posedge gClk);
        lock_o <= 1'b1;  // fifth edge still in reset
    endtask

    task automatic testUsbReset;
        int cycles;
        cycles = 0;
        while (usbReset_o === 1'b1 && cycles < 1100) begin
            @(posedge gClk);
            cycles++;
            @(negedge gClk);
        end
        if (usbReset_o !== 1'b0) abortRun("usbReset_o never fell after lock was released");
        compareBit(cycles >= 1000 && cycles <= 1002, 1'b1,
                   $sformatf("usbReset_o fell %0d cycles after lock", cycles));
    endtask

    task automatic watchResetPulses(input int cycles, output int pulses, output int firstAt);
        pulses = 0;
        firstAt = 0;
        for (int i = 1; i <= cycles; i++) begin
            @(negedge gClk);
            if (memReset_o) begin
                pulses++;
                if (firstAt == 0) firstAt = i;
            end
        end
    endtask

    task automatic testCartChange(input logic level);
        int pulses;
        int firstAt;
        @(posedge gClk);
        cartDetect_i <= level;
        watchResetPulses(25, pulses, firstAt);
        compareBit(pulses == 1, 1'b1,
                   $sformatf("memReset_o pulses for cart %b (%0d)", level, pulses));
        compareBit(firstAt <= 20, 1'b1, $sformatf("memReset_o pulse delay (%0d)", firstAt));
    endtask

    task automatic testCartToggle;
        int pulses;
        pulses = 0;
        for (int i = 0; i < 40; i++) begin
            @(posedge gClk);
            cartDetect_i <= ~cartDetect_i;
            @(negedge gClk);
            if (memReset_o) pulses++;
        end
        compareBit(pulses == 0, 1'b1, $sformatf("memReset_o pulses while toggling (%0d)", pulses));
        @(posedge gClk);
        cartDetect_i <= 1'b1;
        repeat (25) @(posedge gClk);  // let the rise settle
    endtask

    task automatic driveMenu(input logic init, input int cycles, input bit follows);
        logic [31:0] randWord;
        logic        btn;
        for (int i = 0; i < cycles; i++) begin
            @(posedge gClk);
            randWord = $random(seed);
            btn = randWord[0];
            menuInit_i <= init;
            menuBtn_i  <= btn;
            @(negedge gClk);
            compareBit(menuGated_o, follows ? btn : 1'b1, "menuGated_o");
        end
    endtask

    task automatic testMenuGate;
        driveMenu(1'b1, 20, 1'b1);
        driveMenu(1'b0, 10, 1'b0);
        @(posedge gClk);
        cartDetect_i <= 1'b0;
        repeat (8) @(posedge gClk);
        driveMenu(1'b1, 10, 1'b0);  // cart line low
        @(posedge gClk);
        cartDetect_i <= 1'b1;
        menuInit_i   <= 1'b0;
        menuBtn_i    <= 1'b1;
        repeat (25) @(posedge gClk);
    endtask

    task automatic pulseVsync;
        @(posedge gClk);
        lcdVsync_i <= 1'b1;
        repeat (2) @(posedge gClk);
        lcdVsync_i <= 1'b0;
        repeat (4) @(posedge gClk);
        @(negedge gClk);
    endtask

    task automatic testLcdEnable;
        int waited;
        @(posedge gClk);
        lcdReady_i <= 1'b1;
        pulseVsync();
        compareBit(lcdEnable_o, 1'b0, "lcdEnable_o after first vsync");
        pulseVsync();
        compareBit(lcdEnable_o, 1'b0, "lcdEnable_o after second vsync");
        pulseVsync();
        compareBit(lcdEnable_o, 1'b1, "lcdEnable_o after third vsync");
        @(posedge gClk);
        cartDetect_i <= 1'b0;  // cart pulled
        waited = 0;
        do begin
            @(negedge gClk);
            waited++;
        end while (!memReset_o && waited < 25);
        if (!memReset_o) abortRun("no memReset_o pulse after the cart line fell");
        @(negedge gClk);
        compareBit(lcdEnable_o, 1'b0, "lcdEnable_o after memReset_o");
        @(posedge gClk);
        cartDetect_i <= 1'b1;
        lcdReady_i   <= 1'b0;
        repeat (25) @(posedge gClk);
    endtask

    task automatic testMcuBoot;
        logic [31:0] randWord;
        logic        boot;
        @(posedge gClk);
        randWord = $random(seed);
        boot = randWord[0];
        mcuEnableReq_i <= 1'b1;
        mcuBootReq_i   <= boot;
        repeat (8 * MCU_STEP - 1) @(posedge gClk);
        @(negedge gClk);
        compareMcu(mcu_o, '{enable: 1'b0, bootSel: boot}, "mcu_o before 8 steps");
        repeat (MCU_STEP + 3) @(posedge gClk);
        @(negedge gClk);
        compareMcu(mcu_o, '{enable: 1'b1, bootSel: boot}, "mcu_o after 9 steps");
        for (int i = 0; i < 8; i++) begin
            @(posedge gClk);
            randWord = $random(seed);
            boot = randWord[0];
            mcuBootReq_i <= boot;
            @(posedge gClk);
            @(negedge gClk);
            compareMcu(mcu_o, '{enable: 1'b1, bootSel: boot}, "mcu_o boot select");
        end
        @(posedge gClk);
        mcuEnableReq_i <= 1'b0;
        repeat (2) @(posedge gClk);
        @(negedge gClk);
        compareMcu(mcu_o, '{enable: 1'b0, bootSel: boot}, "mcu_o after request fell");
    endtask

    task automatic checkLedPattern(input ledRequest_t req);
        bit isYellow;
        isYellow = !req.white && !req.green && req.yellow;
        @(posedge gClk);
        ledRequest_i <= req;
        repeat (2) @(posedge gClk);
        @(negedge gClk);
        compareLed(led_o, expectedLed(req), !isYellow, $sformatf("led_o for request %b", req));
    endtask

    task automatic testStatusLed;
        logic [31:0] randWord;
        for (int v = 0; v < 16; v++) begin
            checkLedPattern(ledRequest_t'(4'(v)));
        end
        for (int i = 0; i < 32; i++) begin
            randWord = $random(seed);
            checkLedPattern(randWord[3:0]);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abortRun($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        lock_o         = 1'b0;
        cartDetect_i   = 1'b0;
        menuInit_i     = 1'b0;
        menuBtn_i      = 1'b1;
        lcdVsync_i     = 1'b0;
        lcdReady_i     = 1'b0;
        mcuEnableReq_i = 1'b0;
        mcuBootReq_i   = 1'b0;
        ledRequest_i   = '0;
        applyReset();
        testUsbReset();
        testCartChange(1'b1);
        testCartChange(1'b0);
        testCartToggle();
        testMenuGate();
        testLcdEnable();
        testMcuBoot();
        testStatusLed();
        repeat (5) @(posedge gClk);
        if (DUT.peripheralSequencerInst.assertInst.failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display("%0d assertion failures", DUT.peripheralSequencerInst.assertInst.failCount);
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
design/housekeepingPkg.sv
design/tickGen.sv
design/stageLine.sv
design/cartGuard.sv
design/peripheralSequencer.sv
design/statusLed.sv
design/boardTop.sv
testbench/boardTop_assert.sv
testbench/boardTop_tb.sv

/* Bender.yml */
package:
  name: board_housekeeping

sources:
  - design/housekeepingPkg.sv
  - design/tickGen.sv
  - design/stageLine.sv
  - design/cartGuard.sv
  - design/peripheralSequencer.sv
  - design/statusLed.sv
  - design/boardTop.sv
  - target: simulation
    files:
      - testbench/boardTop_assert.sv
      - testbench/boardTop_tb.sv
